// File: flist.f
ieu_pkg.sv
ieu_execute.sv
ieu_result_queue.sv
ieu_commit.sv
ieu_top.sv
tb_clk_gen.sv
tb_ieu_checker.sv
tb_ieu_top.sv

// File: ieu_commit.sv
// Commit stage of the integer unit
// Retires the queue head in order: register write, condition flag,
// branch and far-jump checks, flush handshake and predictor update
`timescale 1ns/1ps
`default_nettype none

module ieu_commit (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      q_valid,
   output logic                      q_ready,
   input  ieu_pkg::ieu_result_t      q_res,
   output logic                      regf_valid,
   input  logic                      regf_ready,
   output ieu_pkg::regf_wr_t         regf_wr,
   output logic                      specul_flush,
   input  logic                      specul_flush_ack,
   output logic [ieu_pkg::PCW-1:0]   flush_tgt,
   output logic                      bpu_wb,
   output ieu_pkg::bpu_upd_t         bpu_upd,
   output logic                      kill
);

   ieu_pkg::flush_st_e            fls_st;
   logic [ieu_pkg::PCW-1:0]       flush_tgt_r;
   logic                          cc_flag;
   logic                          commit;
   logic                          bcc_miss;
   logic                          jmp_miss;
   logic                          mispredict;
   logic [ieu_pkg::PCW-1:0]       miss_tgt;

   assign specul_flush = (fls_st == ieu_pkg::FLS_WAIT);
   assign flush_tgt    = flush_tgt_r;

   // Head waits on the register file only when it writes back
   assign regf_valid   = q_valid & q_res.wb_regf & ~specul_flush;
   assign regf_wr.addr = q_res.wb_reg_addr;
   assign regf_wr.data = q_res.result;

   assign q_ready = ~specul_flush & (~q_res.wb_regf | regf_ready);
   assign commit  = q_valid & q_ready;

   // Branch outcome is judged against the flag as it stands now
   assign bcc_miss   = q_res.is_bcc & (q_res.specul_bcc != cc_flag);
   assign jmp_miss   = q_res.is_jmpfar & (q_res.far_tgt != q_res.specul_tgt);
   assign mispredict = commit & (bcc_miss | jmp_miss);
   assign miss_tgt   = q_res.is_jmpfar ? q_res.far_tgt : q_res.specul_tgt;

   assign kill = mispredict;  // Drops everything younger

   assign bpu_wb         = commit & (q_res.is_bcc | q_res.is_jmpfar);
   assign bpu_upd.jmprel = q_res.is_bcc;
   assign bpu_upd.hit    = ~(bcc_miss | jmp_miss);
   assign bpu_upd.insn_pc = q_res.insn_pc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cc_flag <= 1'b0;
      end else if (commit & q_res.cc_we) begin
         cc_flag <= q_res.cc_nxt;
      end
   end

   // Flush request held until the fetch side acknowledges
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fls_st <= ieu_pkg::FLS_IDLE;
      end else begin
         case (fls_st)
            ieu_pkg::FLS_IDLE: begin
               if (mispredict) begin
                  fls_st <= ieu_pkg::FLS_WAIT;
               end
            end
            ieu_pkg::FLS_WAIT: begin
               if (specul_flush_ack) begin
                  fls_st <= ieu_pkg::FLS_IDLE;
               end
            end
            default: fls_st <= ieu_pkg::FLS_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (mispredict) begin
         flush_tgt_r <= miss_tgt;
      end
   end

   a_flush_hold: assert property (@(posedge clk) disable iff (!rst_n)
      specul_flush && !specul_flush_ack |=> specul_flush && $stable(flush_tgt));

   a_jmp_kind_mutex: assert property (@(posedge clk) disable iff (!rst_n)
      q_valid |-> !(q_res.is_bcc && q_res.is_jmpfar));

endmodule

`default_nettype wire

// File: ieu_execute.sv
// Execute stage of the integer unit
// Computes ALU, compare and link results and holds them in one output register
`timescale 1ns/1ps
`default_nettype none

module ieu_execute (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  ieu_pkg::ieu_op_t     in_op,
   output logic                 ex_valid,
   input  logic                 ex_ready,
   output ieu_pkg::ieu_result_t ex_res,
   input  logic                 kill,
   input  logic                 specul_flush
);

   logic                          accept;
   logic [ieu_pkg::SHAMT_W-1:0]   shamt;
   logic [ieu_pkg::DW-1:0]        sum;
   logic [ieu_pkg::DW-1:0]        diff;
   logic [ieu_pkg::PCW-1:0]       pc_inc;
   logic [ieu_pkg::DW-1:0]        link_addr;
   logic                          cmp_eq;
   logic                          cmp_lt;
   logic                          cmp_ltu;
   ieu_pkg::ieu_result_t          res_nxt;

   // Stage can take a new op when its register drains or is empty
   assign in_ready = (ex_ready | ~ex_valid) & ~specul_flush;
   assign accept   = in_valid & in_ready;

   assign shamt   = in_op.operand_2[ieu_pkg::SHAMT_W-1:0];
   assign sum     = in_op.operand_1 + in_op.operand_2;
   assign diff    = in_op.operand_1 - in_op.operand_2;
   assign cmp_eq  = (in_op.operand_1 == in_op.operand_2);
   assign cmp_lt  = ($signed(in_op.operand_1) < $signed(in_op.operand_2));
   assign cmp_ltu = (in_op.operand_1 < in_op.operand_2);

   // Next instruction address in bytes
   assign pc_inc    = in_op.insn_pc + {{(ieu_pkg::PCW-1){1'b0}}, 1'b1};
   assign link_addr = {pc_inc, 2'b00};

   always_comb begin
      res_nxt             = '0;
      res_nxt.wb_regf     = in_op.wb_regf;
      res_nxt.wb_reg_addr = in_op.wb_reg_addr;
      res_nxt.specul_bcc  = in_op.specul_bcc;
      res_nxt.specul_tgt  = in_op.specul_tgt;
      res_nxt.insn_pc     = in_op.insn_pc;
      res_nxt.far_tgt     = in_op.operand_1[ieu_pkg::DW-1:2];

      case (in_op.opc)
         ieu_pkg::OPC_ADD: res_nxt.result = sum;
         ieu_pkg::OPC_SUB: res_nxt.result = diff;
         ieu_pkg::OPC_AND: res_nxt.result = in_op.operand_1 & in_op.operand_2;
         ieu_pkg::OPC_OR:  res_nxt.result = in_op.operand_1 | in_op.operand_2;
         ieu_pkg::OPC_XOR: res_nxt.result = in_op.operand_1 ^ in_op.operand_2;
         ieu_pkg::OPC_SLL: res_nxt.result = in_op.operand_1 << shamt;
         ieu_pkg::OPC_SRL: res_nxt.result = in_op.operand_1 >> shamt;
         ieu_pkg::OPC_SRA: res_nxt.result = $signed(in_op.operand_1) >>> shamt;
         ieu_pkg::OPC_CMPEQ: begin
            res_nxt.cc_we  = 1'b1;
            res_nxt.cc_nxt = cmp_eq;
         end
         ieu_pkg::OPC_CMPLT: begin
            res_nxt.cc_we  = 1'b1;
            res_nxt.cc_nxt = cmp_lt;
         end
         ieu_pkg::OPC_CMPLTU: begin
            res_nxt.cc_we  = 1'b1;
            res_nxt.cc_nxt = cmp_ltu;
         end
         ieu_pkg::OPC_BCC: begin
            res_nxt.is_bcc = 1'b1;
            res_nxt.result = link_addr;
         end
         ieu_pkg::OPC_JMPFAR: begin
            res_nxt.is_jmpfar = 1'b1;
            res_nxt.result    = link_addr;
         end
         default: res_nxt.result = '0;
      endcase

      // Compares write the flag value as a 0/1 result
      if (res_nxt.cc_we) begin
         res_nxt.result = {{(ieu_pkg::DW-1){1'b0}}, res_nxt.cc_nxt};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else if (kill) begin
         ex_valid <= 1'b0;  // Younger than the mispredicted branch
      end else if (accept) begin
         ex_valid <= 1'b1;
      end else if (ex_ready) begin
         ex_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         ex_res <= res_nxt;
      end
   end

   a_opc_known: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> in_op.opc inside {ieu_pkg::OPC_ADD, ieu_pkg::OPC_SUB,
                                     ieu_pkg::OPC_AND, ieu_pkg::OPC_OR,
                                     ieu_pkg::OPC_XOR, ieu_pkg::OPC_SLL,
                                     ieu_pkg::OPC_SRL, ieu_pkg::OPC_SRA,
                                     ieu_pkg::OPC_CMPEQ, ieu_pkg::OPC_CMPLT,
                                     ieu_pkg::OPC_CMPLTU, ieu_pkg::OPC_BCC,
                                     ieu_pkg::OPC_JMPFAR});

endmodule

`default_nettype wire

// File: ieu_pkg.sv
// Integer execution unit shared definitions
// Widths, opcode encoding and the structs passed between pipeline stages
`default_nettype none

package ieu_pkg;

   localparam int DW      = 32;  // Data path width
   localparam int PCW     = 30;  // Word-aligned program counter
   localparam int REG_AW  = 5;
   localparam int SHAMT_W = 5;

   // Result queue sizing
   localparam int                  Q_PTR_W = 1;
   localparam int                  Q_CNT_W = 2;
   localparam logic [Q_CNT_W-1:0]  Q_DEPTH = 2'd2;

   typedef enum logic [3:0] {
      OPC_ADD    = 4'd0,
      OPC_SUB    = 4'd1,
      OPC_AND    = 4'd2,
      OPC_OR     = 4'd3,
      OPC_XOR    = 4'd4,
      OPC_SLL    = 4'd5,
      OPC_SRL    = 4'd6,
      OPC_SRA    = 4'd7,
      OPC_CMPEQ  = 4'd8,
      OPC_CMPLT  = 4'd9,   // Signed
      OPC_CMPLTU = 4'd10,
      OPC_BCC    = 4'd11,  // Conditional relative branch
      OPC_JMPFAR = 4'd12   // Jump through register
   } ieu_opc_e;

   typedef struct packed {
      ieu_opc_e             opc;
      logic [DW-1:0]        operand_1;
      logic [DW-1:0]        operand_2;
      logic [PCW-1:0]       insn_pc;
      logic [PCW-1:0]       specul_tgt;   // Predicted target
      logic                 specul_bcc;   // Predicted branch outcome
      logic                 wb_regf;
      logic [REG_AW-1:0]    wb_reg_addr;
   } ieu_op_t;

   typedef struct packed {
      logic [DW-1:0]        result;
      logic                 wb_regf;
      logic [REG_AW-1:0]    wb_reg_addr;
      logic                 cc_we;
      logic                 cc_nxt;
      logic                 is_bcc;
      logic                 is_jmpfar;
      logic                 specul_bcc;
      logic [PCW-1:0]       far_tgt;      // operand_1 word address
      logic [PCW-1:0]       specul_tgt;
      logic [PCW-1:0]       insn_pc;
   } ieu_result_t;

   typedef struct packed {
      logic [REG_AW-1:0]    addr;
      logic [DW-1:0]        data;
   } regf_wr_t;

   typedef struct packed {
      logic                 jmprel;
      logic                 hit;
      logic [PCW-1:0]       insn_pc;
   } bpu_upd_t;

   typedef enum logic {
      FLS_IDLE = 1'b0,
      FLS_WAIT = 1'b1      // Flush raised, waiting for ack
   } flush_st_e;

endpackage

`default_nettype wire

// File: ieu_result_queue.sv
// Two-entry result queue between execute and commit
// Registered output, no fall-through; kill drops everything held
`timescale 1ns/1ps
`default_nettype none

module ieu_result_queue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 ex_valid,
   output logic                 ex_ready,
   input  ieu_pkg::ieu_result_t ex_res,
   output logic                 q_valid,
   input  logic                 q_ready,
   output ieu_pkg::ieu_result_t q_res,
   input  logic                 kill
);

   ieu_pkg::ieu_result_t               mem [ieu_pkg::Q_DEPTH];
   logic [ieu_pkg::Q_PTR_W-1:0]        wr_ptr;
   logic [ieu_pkg::Q_PTR_W-1:0]        rd_ptr;
   logic [ieu_pkg::Q_CNT_W-1:0]        count;
   logic                               push;
   logic                               pop;

   assign ex_ready = (count < ieu_pkg::Q_DEPTH);
   assign q_valid  = (count != '0);
   assign q_res    = mem[rd_ptr];

   assign push = ex_valid & ex_ready;
   assign pop  = q_valid & q_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (kill) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= ex_res;
      end
   end

   // A push taken while full would carry the count past the depth
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      count <= ieu_pkg::Q_DEPTH);

   // A pop from empty would wrap the count to its top value
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |=> count < ieu_pkg::Q_DEPTH);

endmodule

`default_nettype wire

// File: ieu_top.sv
// Integer execution unit top level
// Execute stage, result queue and commit stage in a chain
`timescale 1ns/1ps
`default_nettype none

module ieu_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  ieu_pkg::ieu_op_t          in_op,
   output logic                      regf_valid,
   input  logic                      regf_ready,
   output ieu_pkg::regf_wr_t         regf_wr,
   output logic                      specul_flush,
   input  logic                      specul_flush_ack,
   output logic [ieu_pkg::PCW-1:0]   flush_tgt,
   output logic                      bpu_wb,
   output ieu_pkg::bpu_upd_t         bpu_upd
);

   logic                    ex_valid;
   logic                    ex_ready;
   ieu_pkg::ieu_result_t    ex_res;
   logic                    q_valid;
   logic                    q_ready;
   ieu_pkg::ieu_result_t    q_res;
   logic                    kill;

   ieu_execute u_execute (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_op        (in_op),
      .ex_valid     (ex_valid),
      .ex_ready     (ex_ready),
      .ex_res       (ex_res),
      .kill         (kill),
      .specul_flush (specul_flush)
   );

   ieu_result_queue u_result_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_valid (ex_valid),
      .ex_ready (ex_ready),
      .ex_res   (ex_res),
      .q_valid  (q_valid),
      .q_ready  (q_ready),
      .q_res    (q_res),
      .kill     (kill)
   );

   ieu_commit u_commit (
      .clk              (clk),
      .rst_n            (rst_n),
      .q_valid          (q_valid),
      .q_ready          (q_ready),
      .q_res            (q_res),
      .regf_valid       (regf_valid),
      .regf_ready       (regf_ready),
      .regf_wr          (regf_wr),
      .specul_flush     (specul_flush),
      .specul_flush_ack (specul_flush_ack),
      .flush_tgt        (flush_tgt),
      .bpu_wb           (bpu_wb),
      .bpu_upd          (bpu_upd),
      .kill             (kill)
   );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the integer unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_ieu_top -f flist.f -o sim_ieu
./obj_dir/sim_ieu | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: tb_clk_gen.sv
// Testbench clock and reset source
// 40 ns clock, active-low reset held for five rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;  // Released just after an edge
   end

endmodule

`default_nettype wire

// File: tb_ieu_checker.sv
// Integer unit testbench checker
// Reference model of results, flag and mispredicts, plus the scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_ieu_checker (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      in_valid,
   input  logic                      in_ready,
   input  ieu_pkg::ieu_op_t          in_op,
   input  logic                      regf_valid,
   input  logic                      regf_ready,
   input  ieu_pkg::regf_wr_t         regf_wr,
   input  logic                      specul_flush,
   input  logic                      specul_flush_ack,
   input  logic [ieu_pkg::PCW-1:0]   flush_tgt,
   input  logic                      bpu_wb,
   input  ieu_pkg::bpu_upd_t         bpu_upd,
   input  logic [8*12-1:0]           test_name,
   input  logic                      test_done,
   input  logic                      stall_req,
   output logic                      busy,
   output int                        errors,
   output int                        checks
);

   logic [36:0]              exp_wr [$];   // {addr, data}
   logic [31:0]              exp_bpu [$];  // {jmprel, hit, pc}
   logic [ieu_pkg::PCW-1:0]  exp_fl [$];
   logic                     flag;         // Model condition flag
   logic                     discard;      // Younger than an unacked mispredict
   logic                     flush_q;
   int                       n_err = 0;
   int                       n_chk = 0;
   int                       err_base = 0;
   int                       stalls = 0;

   assign errors = n_err;
   assign checks = n_chk;

   task automatic fail_value(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      n_err++;
   endtask

   task automatic fail_note(input string msg);
      $display("ERROR in %s: %s", test_name, msg);
      n_err++;
   endtask

   // Expected outcome of one accepted op, in program order
   task automatic model_op(input ieu_pkg::ieu_op_t op);
      logic [31:0]              a;
      logic [31:0]              b;
      logic [31:0]              res;
      logic [ieu_pkg::PCW-1:0]  far;
      logic                     miss;
      a    = op.operand_1;
      b    = op.operand_2;
      far  = a[31:2];
      miss = 1'b0;
      res  = {op.insn_pc + 30'd1, 2'b00};  // Link address for jumps
      case (op.opc)
         ieu_pkg::OPC_ADD: res = a + b;
         ieu_pkg::OPC_SUB: res = a - b;
         ieu_pkg::OPC_AND: res = a & b;
         ieu_pkg::OPC_OR:  res = a | b;
         ieu_pkg::OPC_XOR: res = a ^ b;
         ieu_pkg::OPC_SLL: res = a << b[4:0];
         ieu_pkg::OPC_SRL: res = a >> b[4:0];
         ieu_pkg::OPC_SRA: res = $signed(a) >>> b[4:0];
         ieu_pkg::OPC_CMPEQ:  res = {31'd0, a == b};
         ieu_pkg::OPC_CMPLT:  res = {31'd0, $signed(a) < $signed(b)};
         ieu_pkg::OPC_CMPLTU: res = {31'd0, a < b};
         ieu_pkg::OPC_BCC:    miss = (op.specul_bcc != flag);
         ieu_pkg::OPC_JMPFAR: miss = (far != op.specul_tgt);
         default: ;
      endcase
      if (op.opc inside {ieu_pkg::OPC_CMPEQ, ieu_pkg::OPC_CMPLT, ieu_pkg::OPC_CMPLTU}) begin
         flag = res[0];
      end
      if (op.wb_regf) exp_wr.push_back({op.wb_reg_addr, res});
      if (op.opc inside {ieu_pkg::OPC_BCC, ieu_pkg::OPC_JMPFAR}) begin
         exp_bpu.push_back({op.opc == ieu_pkg::OPC_BCC, !miss, op.insn_pc});
         if (miss) begin
            exp_fl.push_back(op.opc == ieu_pkg::OPC_BCC ? op.specul_tgt : far);
            discard = 1'b1;
         end
      end
   endtask

   // Everything is sampled mid-cycle, away from the driving edge
   always @(negedge clk) begin
      if (!rst_n) begin
         if (regf_valid || specul_flush || bpu_wb) fail_note("control output high in reset");
         flag    = 1'b0;
         discard = 1'b0;
         flush_q = 1'b0;
      end else begin
         if (in_valid && in_ready && !discard) model_op(in_op);
         if (in_valid && !in_ready && !specul_flush) stalls++;
         if (regf_valid && regf_ready) begin
            n_chk++;
            if (exp_wr.size() == 0) fail_note("register write that no op produced");
            else if (exp_wr[0] !== regf_wr) fail_value("regf write", exp_wr[0], regf_wr);
            if (exp_wr.size() != 0) exp_wr.pop_front();
         end
         if (bpu_wb) begin
            n_chk++;
            if (exp_bpu.size() == 0) fail_note("predictor update without a branch");
            else if (exp_bpu[0] !== bpu_upd) fail_value("bpu update", exp_bpu[0], bpu_upd);
            if (exp_bpu.size() != 0) exp_bpu.pop_front();
         end
         if (specul_flush && !flush_q) begin
            n_chk++;
            if (exp_fl.size() == 0) fail_note("flush raised with no mispredict");
            else if (exp_fl[0] !== flush_tgt) fail_value("flush target", exp_fl[0], flush_tgt);
            if (exp_fl.size() != 0) exp_fl.pop_front();
         end
         if (specul_flush && specul_flush_ack) discard = 1'b0;
         flush_q = specul_flush;
         if (test_done) begin
            if (stall_req && stalls == 0) fail_note("in_ready never dropped under back-pressure");
            $display("TEST %s finished with %0d errors", test_name, n_err - err_base);
            err_base = n_err;
            stalls   = 0;
         end
      end
      busy <= (exp_wr.size() != 0) || (exp_bpu.size() != 0) || (exp_fl.size() != 0)
              || discard || specul_flush;
   end

endmodule

`default_nettype wire

// File: tb_ieu_top.sv
// Integer execution unit testbench
// Table of tests applied in order, with random operands and regf back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_ieu_top;

   typedef struct packed {
      ieu_pkg::ieu_opc_e  opc;
      logic               mod;  // Per-opcode variant, see build_op
      logic               wb;
   } tpl_t;

   typedef struct packed {
      logic [8*12-1:0]    name;
      int                 first;  // First entry in OPS
      int                 len;
      int                 rep;    // Passes over the op list
      logic               rand_rdy;
      int                 ack_dly;
   } test_t;

   localparam tpl_t OPS [26] = '{
      '{ieu_pkg::OPC_BCC, 1'b0, 1'b1},    '{ieu_pkg::OPC_ADD, 1'b0, 1'b1},
      '{ieu_pkg::OPC_ADD, 1'b0, 1'b1},    '{ieu_pkg::OPC_SUB, 1'b0, 1'b1},
      '{ieu_pkg::OPC_AND, 1'b0, 1'b1},    '{ieu_pkg::OPC_OR, 1'b0, 1'b1},
      '{ieu_pkg::OPC_XOR, 1'b0, 1'b1},    '{ieu_pkg::OPC_SLL, 1'b0, 1'b1},
      '{ieu_pkg::OPC_SRL, 1'b0, 1'b1},    '{ieu_pkg::OPC_SRA, 1'b0, 1'b1},
      '{ieu_pkg::OPC_CMPEQ, 1'b1, 1'b1},  '{ieu_pkg::OPC_BCC, 1'b1, 1'b1},
      '{ieu_pkg::OPC_CMPLT, 1'b0, 1'b1},  '{ieu_pkg::OPC_CMPLTU, 1'b0, 1'b1},
      '{ieu_pkg::OPC_CMPEQ, 1'b0, 1'b1},  '{ieu_pkg::OPC_BCC, 1'b0, 1'b0},
      '{ieu_pkg::OPC_CMPEQ, 1'b1, 1'b1},  '{ieu_pkg::OPC_BCC, 1'b0, 1'b1},  // Mispredict
      '{ieu_pkg::OPC_ADD, 1'b0, 1'b1},    '{ieu_pkg::OPC_XOR, 1'b0, 1'b1},
      '{ieu_pkg::OPC_SUB, 1'b0, 1'b1},    '{ieu_pkg::OPC_ADD, 1'b0, 1'b1},
      '{ieu_pkg::OPC_JMPFAR, 1'b0, 1'b1}, '{ieu_pkg::OPC_ADD, 1'b0, 1'b1},
      '{ieu_pkg::OPC_JMPFAR, 1'b1, 1'b1}, '{ieu_pkg::OPC_ADD, 1'b0, 1'b1}
   };

   localparam test_t TESTS [6] = '{
      '{"reset_flag  ", 0, 2, 1, 1'b0, 0},
      '{"arith_logic ", 2, 8, 3, 1'b0, 0},
      '{"compare_flag", 10, 6, 2, 1'b0, 0},
      '{"bcc_mispred ", 16, 6, 2, 1'b0, 3},
      '{"far_jump    ", 22, 4, 2, 1'b0, 1},
      '{"backpressure", 2, 8, 4, 1'b1, 0}   // Reuses the ALU ops
   };

   logic                      clk;
   logic                      rst_n;
   logic                      in_valid;
   logic                      in_ready;
   ieu_pkg::ieu_op_t          in_op;
   logic                      regf_valid;
   logic                      regf_ready;
   ieu_pkg::regf_wr_t         regf_wr;
   logic                      specul_flush;
   logic                      specul_flush_ack;
   logic [ieu_pkg::PCW-1:0]   flush_tgt;
   logic                      bpu_wb;
   ieu_pkg::bpu_upd_t         bpu_upd;
   logic [8*12-1:0]           test_name;
   logic                      test_done;
   logic                      rand_rdy;
   logic                      busy;
   int                        errors;
   int                        checks;
   int                        ack_dly;
   logic [31:0]               rnd;
   test_t                     cur;
   ieu_pkg::ieu_op_t          op;

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   ieu_top u_ieu_top (
      .clk(clk), .rst_n(rst_n),
      .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
      .regf_valid(regf_valid), .regf_ready(regf_ready), .regf_wr(regf_wr),
      .specul_flush(specul_flush), .specul_flush_ack(specul_flush_ack),
      .flush_tgt(flush_tgt), .bpu_wb(bpu_wb), .bpu_upd(bpu_upd)
   );

   tb_ieu_checker u_checker (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
      .regf_valid(regf_valid), .regf_ready(regf_ready), .regf_wr(regf_wr),
      .specul_flush(specul_flush), .specul_flush_ack(specul_flush_ack),
      .flush_tgt(flush_tgt), .bpu_wb(bpu_wb), .bpu_upd(bpu_upd),
      .test_name(test_name), .test_done(test_done), .stall_req(rand_rdy),
      .busy(busy), .errors(errors), .checks(checks)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic int total_ops();
      int n;
      n = 0;
      foreach (TESTS[t]) n += TESTS[t].len * TESTS[t].rep;
      return n;
   endfunction

   // Random operands; mod forces equal compares, predicted taken, or a matching jump
   task automatic build_op(input tpl_t t, output ieu_pkg::ieu_op_t o);
      o = '0;
      o.opc = t.opc;
      o.wb_regf = t.wb;
      rnd = xorshift(rnd);
      o.operand_1 = rnd;
      rnd = xorshift(rnd);
      o.operand_2 = (t.opc == ieu_pkg::OPC_CMPEQ && t.mod) ? o.operand_1 : rnd;
      rnd = xorshift(rnd);
      o.insn_pc = rnd[31:2];
      o.wb_reg_addr = rnd[4:0];
      o.specul_tgt = {rnd[1:0], rnd[31:4]};
      o.specul_bcc = (t.opc == ieu_pkg::OPC_BCC) && t.mod;
      if (t.opc == ieu_pkg::OPC_JMPFAR) begin
         o.specul_tgt = t.mod ? o.operand_1[31:2] : ~o.operand_1[31:2];
      end
   endtask

   // One clock, then new regf_ready just after the edge
   task automatic step();
      @(posedge clk);
      #1;
      rnd = xorshift(rnd);
      regf_ready = rand_rdy ? rnd[3] : 1'b1;
   endtask

   initial begin
      in_valid   = 1'b0;
      in_op      = '0;
      regf_ready = 1'b1;
      test_done  = 1'b0;
      rand_rdy   = 1'b0;
      ack_dly    = 0;
      test_name  = TESTS[0].name;
      rnd        = 32'h303e;
      @(posedge rst_n);
      step();
      for (int t = 0; t < 6; t++) begin
         cur       = TESTS[t];
         test_name = cur.name;
         rand_rdy  = cur.rand_rdy;
         ack_dly   = cur.ack_dly;
         for (int r = 0; r < cur.rep; r++) begin
            for (int i = 0; i < cur.len; i++) begin
               build_op(OPS[cur.first + i], op);
               step();
               in_valid = 1'b1;
               in_op    = op;
               @(negedge clk);
               while (!in_ready) begin
                  step();
                  @(negedge clk);
               end
            end
         end
         step();
         in_valid = 1'b0;
         while (busy) step();
         test_done = 1'b1;
         step();
         test_done = 1'b0;
      end
      $display("Done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // Fetch side answers a flush after the test's delay
   initial begin
      specul_flush_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (specul_flush) begin
            repeat (ack_dly + 1) @(posedge clk);
            #1 specul_flush_ack = 1'b1;
            @(posedge clk);
            #1 specul_flush_ack = 1'b0;
         end
      end
   end

   initial begin
      int limit;
      limit = total_ops() * 20 + 200;
      repeat (limit) @(posedge clk);
      $display("TIMEOUT: tests did not complete within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
